// File: Makefile
# Verilator build and run of the accumCore testbench
TOP = accumCore_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Verification failed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: hw/accumCore.sv
`timescale 1ns/100ps

module accumCore (
	input logic aluClk,
	input logic arstN,
	input accumPkg::instrWord_t instr,
	input accumPkg::pcAddr_t pc,
	output accumPkg::exOut_t exOut,
	output accumPkg::data_t acumA,
	output accumPkg::data_t acumB
);
	import accumPkg::*;

	decodedInstr_t dec;

	// decode stage
	instrDecoder decoder (
		.instr(instr),
		.pc(pc),
		.dec(dec)
	);

	// execute stage
	executeStage execute (
		.aluClk(aluClk),
		.arstN(arstN),
		.dec(dec),
		.acumA(acumA),
		.acumB(acumB),
		.exOut(exOut)
	);

	// write back
	accumulators accums (
		.aluClk(aluClk),
		.arstN(arstN),
		.exOut(exOut),
		.acumA(acumA),
		.acumB(acumB)
	);

endmodule

// File: hw/accumPkg.sv
package accumPkg;

	// ------------------------------------------------------------------------
	// widths fixed by the 16-bit instruction format
	// ------------------------------------------------------------------------
	localparam int dataWidth = 8;
	localparam int opWidth = 6;
	localparam int addrWidth = 10;
	// relative branch offset, low bits of the info field
	localparam int relWidth = 6;

	typedef logic signed [dataWidth-1:0] data_t;
	typedef logic [addrWidth-1:0] pcAddr_t;
	// opcode on top, info field below
	typedef logic [opWidth+addrWidth-1:0] instrWord_t;

	// opcodes, numbered 0 to 29 in this order
	typedef enum logic [opWidth-1:0] {
		NOP, LDCA, LDCB,
		ADDA, ADDB, ADDCA, ADDCB,
		SUBA, SUBB, SUBCA, SUBCB,
		ANDA, ANDB, ANDCA, ANDCB,
		ORA, ORB, ORCA, ORCB,
		ASLA, ASRA,
		JMP,
		BAEQ, BANE, BAMI, BAPL,
		BBEQ, BBNE, BBMI, BBPL
	} opcode_t;

	// accumulator write control
	typedef enum logic [2:0] {
		noLoad,
		loadConstA,
		loadResultA,
		loadConstB,
		loadResultB
	} acumCtrl_t;

	// bit 1 picks acc A for oper1, bit 0 picks acc B for oper2
	typedef enum logic [1:0] {
		selConstants,
		selConstAAcumB,
		selAcumAConstB,
		selAcumAB
	} operandSel_t;

	typedef struct packed {
		opcode_t op;
		acumCtrl_t ctrl;
		operandSel_t sel;
		data_t constant;
		pcAddr_t branchTarget;
	} decodedInstr_t;

	typedef struct packed {
		opcode_t op;
		data_t aluData;
		acumCtrl_t ctrl;
		logic branchTaken;
		pcAddr_t branchTarget;
	} exOut_t;

	// which accumulator a ctrl value writes
	function automatic logic writesA(acumCtrl_t ctrl);
		return (ctrl == loadConstA) || (ctrl == loadResultA);
	endfunction

	function automatic logic writesB(acumCtrl_t ctrl);
		return (ctrl == loadConstB) || (ctrl == loadResultB);
	endfunction

endpackage

// File: hw/accumulators.sv
`timescale 1ns/100ps

module accumulators (
	input logic aluClk,
	input logic arstN,
	input accumPkg::exOut_t exOut,
	output accumPkg::data_t acumA,
	output accumPkg::data_t acumB
);
	import accumPkg::*;

	// write lands one edge after the execute result appears
	always_ff @(posedge aluClk or negedge arstN) begin
		if (!arstN) begin
			acumA <= '0;
			acumB <= '0;
		end else begin
			// ctrl names at most one target
			if (writesA(exOut.ctrl)) begin
				acumA <= exOut.aluData;
			end
			if (writesB(exOut.ctrl)) begin
				acumB <= exOut.aluData;
			end
		end
	end

endmodule

// File: hw/alu.sv
`timescale 1ns/100ps

module alu (
	input accumPkg::opcode_t op,
	input accumPkg::data_t oper1,
	input accumPkg::data_t oper2,
	output accumPkg::data_t aluData,
	output logic branchTaken
);
	import accumPkg::*;

	always_comb begin
		// branches, JMP and NOP leave zero
		aluData = '0;
		branchTaken = 1'b0;
		case (op)
			// both operands carry the constant
			LDCA, LDCB: aluData = oper1;
			// add commutes, operand order irrelevant
			ADDA, ADDB, ADDCA, ADDCB: aluData = oper1 + oper2;
			// A - B or A - const
			SUBA, SUBB, SUBCA: aluData = oper1 - oper2;
			// B - const, constant on oper1
			SUBCB: aluData = oper2 - oper1;
			ANDA, ANDB, ANDCA, ANDCB: aluData = oper1 & oper2;
			ORA, ORB, ORCA, ORCB: aluData = oper1 | oper2;
			ASLA: aluData = oper1 <<< 1;
			// signed type keeps the sign bit
			ASRA: aluData = oper1 >>> 1;
			JMP: branchTaken = 1'b1;
			// ----------------------------------------------------------------
			// A conditions on oper1
			// ----------------------------------------------------------------
			BAEQ: branchTaken = (oper1 == '0);
			BANE: branchTaken = (oper1 != '0);
			BAMI: branchTaken = oper1[dataWidth-1];
			BAPL: branchTaken = !oper1[dataWidth-1];
			// ----------------------------------------------------------------
			// B conditions on oper2
			// ----------------------------------------------------------------
			BBEQ: branchTaken = (oper2 == '0);
			BBNE: branchTaken = (oper2 != '0);
			BBMI: branchTaken = oper2[dataWidth-1];
			BBPL: branchTaken = !oper2[dataWidth-1];
			default: begin
				aluData = '0;
				branchTaken = 1'b0;
			end
		endcase
	end

endmodule

// File: hw/executeStage.sv
`timescale 1ns/100ps

module executeStage (
	input logic aluClk,
	input logic arstN,
	input accumPkg::decodedInstr_t dec,
	input accumPkg::data_t acumA,
	input accumPkg::data_t acumB,
	output accumPkg::exOut_t exOut
);
	import accumPkg::*;

	localparam decodedInstr_t nopInstr = '{
		op: NOP, ctrl: noLoad, sel: selConstants, constant: '0, branchTarget: '0
	};

	decodedInstr_t idEx;
	data_t rawA;
	data_t rawB;
	data_t fwdA;
	data_t fwdB;
	data_t oper1;
	data_t oper2;
	data_t aluData;
	logic branchTaken;

	// ID/EX register, NOP out of reset
	always_ff @(posedge aluClk or negedge arstN) begin
		if (!arstN) begin
			idEx <= nopInstr;
		end else begin
			idEx <= dec;
		end
	end

	// accumulators sampled with the instruction
	always_ff @(posedge aluClk) begin
		rawA <= acumA;
		rawB <= acumB;
	end

	// exOut loops back as the write leaving execute
	forwardUnit fwd (
		.aluClk(aluClk),
		.arstN(arstN),
		.prevOut(exOut),
		.rawA(rawA),
		.rawB(rawB),
		.operA(fwdA),
		.operB(fwdB)
	);

	// operand muxes
	assign oper1 = idEx.sel[1] ? fwdA : idEx.constant;
	assign oper2 = idEx.sel[0] ? fwdB : idEx.constant;

	alu aluEx (
		.op(idEx.op),
		.oper1(oper1),
		.oper2(oper2),
		.aluData(aluData),
		.branchTaken(branchTaken)
	);

	assign exOut = '{
		op: idEx.op,
		aluData: aluData,
		ctrl: idEx.ctrl,
		branchTaken: branchTaken,
		branchTarget: idEx.branchTarget
	};

endmodule

// File: hw/forwardUnit.sv
`timescale 1ns/100ps

module forwardUnit (
	input logic aluClk,
	input logic arstN,
	input accumPkg::exOut_t prevOut,
	input accumPkg::data_t rawA,
	input accumPkg::data_t rawB,
	output accumPkg::data_t operA,
	output accumPkg::data_t operB
);
	import accumPkg::*;

	// last write leaving execute
	acumCtrl_t lastCtrl;
	data_t lastData;

	always_ff @(posedge aluClk or negedge arstN) begin
		if (!arstN) begin
			lastCtrl <= noLoad;
		end else begin
			lastCtrl <= prevOut.ctrl;
		end
	end

	// only meaningful while lastCtrl names a target
	always_ff @(posedge aluClk) begin
		lastData <= prevOut.aluData;
	end

	// ------------------------------------------------------------------------
	// raw values were sampled on the same edge that the previous write
	// landed, so they miss it; substitute the kept result
	// ------------------------------------------------------------------------
	assign operA = writesA(lastCtrl) ? lastData : rawA;
	assign operB = writesB(lastCtrl) ? lastData : rawB;

endmodule

// File: hw/instrDecoder.sv
`timescale 1ns/100ps

module instrDecoder (
	input accumPkg::instrWord_t instr,
	input accumPkg::pcAddr_t pc,
	output accumPkg::decodedInstr_t dec
);
	import accumPkg::*;

	logic [opWidth-1:0] opField;
	logic [addrWidth-1:0] infoField;

	assign opField = instr[opWidth+addrWidth-1:addrWidth];
	assign infoField = instr[addrWidth-1:0];

	always_comb begin
		dec.op = opcode_t'(opField);
		// constant sits in the low byte
		dec.constant = infoField[dataWidth-1:0];
		// JMP reaches the whole program space directly
		if (opField == JMP) begin
			dec.branchTarget = infoField;
		end else begin
			// zero-extended offset, wraps at 1024
			dec.branchTarget = pc + pcAddr_t'(infoField[relWidth-1:0]);
		end
		case (opField)
			LDCA: begin
				dec.ctrl = loadConstA;
				dec.sel = selConstants;
			end
			LDCB: begin
				dec.ctrl = loadConstB;
				dec.sel = selConstants;
			end
			// A <- A op B, shifts only use A
			ADDA, SUBA, ANDA, ORA, ASLA, ASRA: begin
				dec.ctrl = loadResultA;
				dec.sel = selAcumAB;
			end
			// B <- A op B
			ADDB, SUBB, ANDB, ORB: begin
				dec.ctrl = loadResultB;
				dec.sel = selAcumAB;
			end
			// A <- A op const
			ADDCA, SUBCA, ANDCA, ORCA: begin
				dec.ctrl = loadResultA;
				dec.sel = selAcumAConstB;
			end
			// B <- B op const, constant rides on oper1
			ADDCB, SUBCB, ANDCB, ORCB: begin
				dec.ctrl = loadResultB;
				dec.sel = selConstAAcumB;
			end
			// conditional branches test the accumulators
			BAEQ, BANE, BAMI, BAPL, BBEQ, BBNE, BBMI, BBPL: begin
				dec.ctrl = noLoad;
				dec.sel = selAcumAB;
			end
			JMP, NOP: begin
				dec.ctrl = noLoad;
				dec.sel = selConstants;
			end
			// unknown codes behave as NOP
			default: begin
				dec.op = NOP;
				dec.ctrl = noLoad;
				dec.sel = selConstants;
			end
		endcase
	end

endmodule

// File: sources.f
hw/accumPkg.sv
hw/instrDecoder.sv
hw/accumulators.sv
hw/forwardUnit.sv
hw/alu.sv
hw/executeStage.sv
hw/accumCore.sv
testbench/accumCore_properties.sv
testbench/accumCore_tb.sv

// File: testbench/accumCore_properties.sv
`timescale 1ns/100ps

module accumCore_properties (
	input logic aluClk,
	input logic arstN,
	input accumPkg::exOut_t exOut
);
	import accumPkg::*;

	logic isBranch;
	logic noWrite;

	// JMP and the conditional branches
	assign isBranch = exOut.op inside {JMP, BAEQ, BANE, BAMI, BAPL, BBEQ, BBNE, BBMI, BBPL};
	// branches and NOP never write an accumulator
	assign noWrite = isBranch || (exOut.op == NOP);

	// ID/EX holds NOP in reset
	resetQuiet: assert property (@(posedge aluClk) !arstN |-> !exOut.branchTaken)
		else $error("branchTaken high during reset");

	takenOnBranch: assert property (@(posedge aluClk) disable iff (!arstN)
		exOut.branchTaken |-> isBranch)
		else $error("branchTaken set for opcode %0d", exOut.op);

	// ------------------------------------------------------------------------
	// write control of non-writing opcodes
	// ------------------------------------------------------------------------
	branchNoLoad: assert property (@(posedge aluClk) disable iff (!arstN)
		noWrite |-> exOut.ctrl == noLoad)
		else $error("ctrl %0d for opcode %0d, expected noLoad", exOut.ctrl, exOut.op);

endmodule

// File: testbench/accumCore_tb.sv
`timescale 1ns/100ps

module accumCore_tb;
	import accumPkg::*;

	localparam int clkPeriod = 4;
	localparam int driveDelay = 1;
	localparam int resetCycles = 5;

	// ------------------------------------------------------------------------
	// one vector of the data file, expected values after the instruction
	// ------------------------------------------------------------------------
	typedef struct packed {
		instrWord_t instr;
		pcAddr_t pc;
		data_t aluData;
		logic taken;
		pcAddr_t target;
		data_t acumA;
		data_t acumB;
	} vector_t;

	logic aluClk;
	logic arstN;
	instrWord_t instr;
	pcAddr_t pc;
	exOut_t exOut;
	data_t acumA;
	data_t acumB;

	vector_t vecs[$];
	// first vector index and number of each test
	int testStart[$];
	int testNum[$];
	int errors;
	int testsFailed;
	logic loaded;

	accumCore UUT (
		.aluClk(aluClk),
		.arstN(arstN),
		.instr(instr),
		.pc(pc),
		.exOut(exOut),
		.acumA(acumA),
		.acumB(acumB)
	);

	// properties watch the execute output
	bind executeStage accumCore_properties props (
		.aluClk(aluClk),
		.arstN(arstN),
		.exOut(exOut)
	);

	initial aluClk = 1'b0;
	always #(clkPeriod / 2) aluClk = ~aluClk;

	// opcode from the top 6 bits, codes past BBPL act as NOP
	function automatic opcode_t opcodeOf(input instrWord_t w);
		logic [opWidth-1:0] code;
		code = w[opWidth+addrWidth-1:addrWidth];
		if (code > BBPL) begin
			return NOP;
		end
		return opcode_t'(code);
	endfunction

	// accumulator target from the instruction semantics
	function automatic acumCtrl_t writeCtrlOf(input opcode_t op);
		case (op)
			LDCA: return loadConstA;
			LDCB: return loadConstB;
			ADDA, SUBA, ANDA, ORA, ADDCA, SUBCA, ANDCA, ORCA, ASLA, ASRA:
				return loadResultA;
			ADDB, SUBB, ANDB, ORB, ADDCB, SUBCB, ANDCB, ORCB:
				return loadResultB;
			default: return noLoad;
		endcase
	endfunction

	task automatic checkData(input string name, input data_t expected, input data_t actual);
		if (actual !== expected) begin
			$display("Fail at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("Fail at %0d ns: %s expected %b, got %b", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic checkTarget(input string name, input pcAddr_t expected, input pcAddr_t actual);
		if (actual !== expected) begin
			$display("Fail at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic checkOp(input string name, input opcode_t expected, input opcode_t actual);
		if (actual !== expected) begin
			$display("Fail at %0d ns: %s expected %0d, got %0d", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic checkCtrl(input string name, input acumCtrl_t expected,
		input acumCtrl_t actual);
		if (actual !== expected) begin
			$display("Fail at %0d ns: %s expected %0d, got %0d", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic readVectors();
		int fd;
		int num;
		string line;
		logic [15:0] fInstr;
		logic [9:0] fPc;
		logic [7:0] fAlu;
		logic fTaken;
		logic [9:0] fTarget;
		logic [7:0] fA;
		logic [7:0] fB;
		fd = $fopen("testbench/accumCore_testdata.txt", "r");
		if (fd == 0) begin
			$display("the test data file could not be opened");
			errors++;
			return;
		end
		while ($fgets(line, fd) > 0) begin
			// skip comments and blank lines
			if (line.len() < 2 || line.getc(0) == "#") begin
				continue;
			end
			// tag line opens a new test
			if ($sscanf(line, "test %d", num) == 1) begin
				testStart.push_back(vecs.size());
				testNum.push_back(num);
			end else if ($sscanf(line, "%h %h %h %h %h %h %h",
					fInstr, fPc, fAlu, fTaken, fTarget, fA, fB) == 7) begin
				vecs.push_back({fInstr, fPc, fAlu, fTaken, fTarget, fA, fB});
			end
		end
		$fclose(fd);
	endtask

	// exOut of the instruction sampled at the last edge
	task automatic verifyExecute(input vector_t v);
		checkOp("exOut.op", opcodeOf(v.instr), exOut.op);
		checkCtrl("exOut.ctrl", writeCtrlOf(opcodeOf(v.instr)), exOut.ctrl);
		checkData("exOut.aluData", v.aluData, exOut.aluData);
		checkFlag("exOut.branchTaken", v.taken, exOut.branchTaken);
		checkTarget("exOut.branchTarget", v.target, exOut.branchTarget);
	endtask

	task automatic verifyAccums(input vector_t v);
		checkData("acumA", v.acumA, acumA);
		checkData("acumB", v.acumB, acumB);
	endtask

	// ------------------------------------------------------------------------
	// one vector per cycle, then two NOPs to drain execute and write back
	// ------------------------------------------------------------------------
	task automatic runTest(input int t);
		int first;
		int last;
		int startErrors;
		first = testStart[t];
		last = (t + 1 < testStart.size()) ? testStart[t + 1] : vecs.size();
		startErrors = errors;
		for (int c = first; c < last + 2; c++) begin
			@(posedge aluClk);
			#driveDelay;
			instr = (c < last) ? vecs[c].instr : '0;
			pc = (c < last) ? vecs[c].pc : '0;
			// mid-cycle, exOut belongs to c-1 and the accumulators to c-2
			@(negedge aluClk);
			if (c - 1 >= first && c - 1 < last) begin
				verifyExecute(vecs[c - 1]);
			end
			if (c - 2 >= first) begin
				verifyAccums(vecs[c - 2]);
			end
		end
		if (errors != startErrors) begin
			testsFailed++;
		end
		$display("test %0d: %0d vectors, %0d mismatches", testNum[t], last - first,
			errors - startErrors);
	endtask

	initial begin
		errors = 0;
		testsFailed = 0;
		loaded = 1'b0;
		arstN = 1'b0;
		instr = '0;
		pc = '0;
		readVectors();
		if (vecs.size() == 0) begin
			$display("no test vectors were read");
			errors++;
		end
		loaded = 1'b1;
		repeat (resetCycles) @(posedge aluClk);
		#driveDelay;
		arstN = 1'b1;
		for (int t = 0; t < testStart.size(); t++) begin
			runTest(t);
		end
		$display("%0d tests run, %0d failed, %0d mismatches", testStart.size(), testsFailed,
			errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	// watchdog, sized from the vector count
	initial begin
		wait (loaded === 1'b1);
		#((vecs.size() + 20) * clkPeriod);
		$display("the run timed out before all tests finished");
		$display("Verification failed");
		$finish;
	end

endmodule

// File: testbench/accumCore_testdata.txt
# columns, all hex: instr pc aluData branchTaken branchTarget acumA acumB
# acumA and acumB are the values after the instruction has written back
test 1 reset and constant loads
0000 000 00 0 000 00 00
047A 001 7A 0 03B 7A 00
0893 002 93 0 015 7A 93
test 2 register and constant forms, NOP separated
0C00 010 0D 0 010 0D 93
0000 011 00 0 011 0D 93
2000 012 7A 0 012 0D 7A
0000 013 00 0 013 0D 7A
34F5 014 05 0 049 05 7A
0000 015 00 0 015 05 7A
4881 016 FB 0 017 05 FB
0000 017 00 0 017 05 FB
2810 018 EB 0 028 05 EB
test 3 shifts
0496 020 96 0 036 96 EB
5000 021 CB 0 021 CB EB
4C00 022 96 0 022 96 EB
0435 023 35 0 058 35 EB
5000 024 1A 0 024 1A EB
4C00 025 34 0 025 34 EB
test 4 forwarding
0440 030 40 0 030 40 EB
0C00 031 2B 0 031 2B EB
2000 032 40 0 032 2B 40
080C 033 0C 0 03F 2B 0C
4821 034 2D 0 055 2B 2D
test 5 branches
57A5 040 00 1 3A5 2B 2D
0400 041 00 0 041 00 2D
583F 3F0 00 1 02F 00 2D
3400 042 00 0 042 00 2D
5C05 043 00 0 048 00 2D
1490 044 90 0 054 90 2D
603C 3E0 00 1 01C 90 2D
4401 045 91 0 046 91 2D
6402 046 00 0 048 91 2D
087F 050 7F 0 08F 91 7F
6801 051 00 0 052 91 7F
2000 052 12 0 052 91 12
6C10 053 00 1 063 91 12
3000 054 10 0 054 91 10
7008 055 00 0 05D 91 10
1805 056 15 0 05B 91 15
7400 057 00 1 057 91 15
